//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_cdi_host_glue
	@out="$$(./obj_dir/Vtb_cdi_host_glue)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- sources.f
+incdir+verilog
verilog/cdi_glue_pkg.sv
verilog/sdram_prepare_arbiter.sv
verilog/worm_byte_splitter.sv
verilog/nvram_change_monitor.sv
verilog/nvram_transfer_sequencer.sv
verilog/cdi_host_glue.sv
verif/tb_cdi_host_glue.sv

//--- verif/tb_cdi_host_glue.sv
`timescale 1ns/10ps

module tb_cdi_host_glue
    import cdi_glue_pkg::*;
();

    // Loader stimulus with expected SDRAM word, or WORM low address and {high, low} bytes
    typedef struct packed {
        logic         slave;
        loader_addr_t addr;
        sdram_word_t  data;
        sdram_addr_t  exp_addr;
        sdram_word_t  exp_word;
    } stim_entry_t;

    localparam int NUM_ENTRIES = 7;

    logic          clk_sys = 1'b0;
    logic          cditop_reset;
    logic          core_hold;
    logic          osd_open;
    logic          ioctl_download;
    logic          ioctl_wr;
    loader_index_t ioctl_index;
    loader_addr_t  ioctl_addr;
    sdram_word_t   ioctl_dout;
    logic          download_overflow;
    sdram_addr_t   core_addr;
    sdram_word_t   core_din;
    logic          core_rd;
    logic          core_wr;
    logic          core_word;
    logic          core_refresh;
    logic          core_burst;
    sdram_addr_t   sdram_addr;
    sdram_word_t   sdram_din;
    logic          sdram_rd;
    logic          sdram_wr;
    logic          sdram_word;
    logic          sdram_refresh;
    logic          sdram_burst;
    logic          sdram_busy;
    worm_addr_t    worm_adr;
    byte_t         worm_data;
    logic          worm_wr;
    logic          nvram_media_change;
    logic [63:0]   img_size;
    logic          nvram_hps_ack;
    logic [7:0]    sd_buff_addr;
    logic          sd_buff_wr;
    sdram_word_t   sd_buff_dout;
    logic          nvram_hps_rd;
    logic          nvram_hps_wr;
    sdram_word_t   nvram_hps_din;
    logic          nvram_cpu_changed;
    byte_t         nvram_backup_data;
    nvram_addr_t   nvram_backup_restore_adr;
    byte_t         nvram_restore_data;
    logic          nvram_restore_write;
    logic          nvram_allow_cpu_access;
    logic          led_user;

    stim_entry_t stim_table [NUM_ENTRIES];
    sdram_word_t rst_words [8];
    byte_t       nv_mem [16];
    logic [3:0]  nv_sample_adr;
    nvram_addr_t worm_log_adr [4];
    byte_t       worm_log_data [4];

    integer      seed = 66;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_start;
    int          wr_count = 0;
    int          ref_count = 0;
    int          acc_count = 0;
    int          worm_count = 0;
    int          busy_left = 0;
    logic        accept_now = 1'b0;
    sdram_addr_t last_wr_addr;
    sdram_word_t last_wr_din;
    logic        last_rd;
    logic        last_wr;
    logic        last_word;
    logic        last_refresh;
    logic        last_burst;

    cdi_host_glue #(
        .BOOT_IGNORE_CYCLES(16)
    ) dut_i (.*);

    initial begin
        forever #4 clk_sys = ~clk_sys;
    end

    // ==================================================
    // SDRAM, NvRAM and WORM models
    // ==================================================

    // Commands sampled mid cycle, busy for 3 cycles after each accept
    always @(negedge clk_sys) begin
        accept_now = !sdram_busy && (sdram_rd || sdram_wr);
        if (accept_now) begin
            acc_count++;
            last_rd      = sdram_rd;
            last_wr      = sdram_wr;
            last_word    = sdram_word;
            last_refresh = sdram_refresh;
            last_burst   = sdram_burst;
            if (sdram_wr) begin
                wr_count++;
                last_wr_addr = sdram_addr;
                last_wr_din  = sdram_din;
            end
            if (sdram_rd && sdram_refresh) begin
                ref_count++;
            end
        end
        if (worm_wr && worm_count < 4) begin
            worm_log_adr[worm_count]  = worm_adr;
            worm_log_data[worm_count] = worm_data;
            worm_count++;
        end
    end

    always @(posedge clk_sys) begin
        #1;
        if (accept_now) begin
            busy_left = 3;
        end else if (busy_left > 0) begin
            busy_left--;
        end
        sdram_busy = (busy_left != 0);
    end

    // One cycle read latency
    always @(posedge clk_sys) begin
        nv_sample_adr = nvram_backup_restore_adr[3:0];
        if (nvram_restore_write) begin
            nv_mem[nv_sample_adr] = nvram_restore_data;
        end
        #1 nvram_backup_data = nv_mem[nv_sample_adr];
    end

    // ==================================================
    // Helpers and compare tasks
    // ==================================================

    task automatic tick();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic check_word(string name, sdram_word_t got, sdram_word_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(string name, sdram_addr_t got, sdram_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_nv_addr(string name, nvram_addr_t got, nvram_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_error(string what);
        $display("Timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_err_start);
        end
    endtask

    task automatic load_word(int i);
        ioctl_wr    = 1'b1;
        ioctl_index = stim_table[i].slave ? 16'h0040 : 16'h0000;
        ioctl_addr  = stim_table[i].addr;
        ioctl_dout  = stim_table[i].data;
        tick();
        ioctl_wr = 1'b0;
    endtask

    task automatic wait_refresh();
        int prev;
        int n;
        prev = ref_count;
        n = 0;
        while (ref_count == prev && n < 40) begin
            tick();
            n++;
        end
        if (ref_count == prev) begin
            timeout_error("a refresh command");
        end
    endtask

    task automatic wait_cpu_access();
        int n;
        n = 0;
        while (!nvram_allow_cpu_access && n < 40) begin
            tick();
            n++;
        end
        check_bit("nvram_allow_cpu_access", nvram_allow_cpu_access, 1'b1);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        int          n;
        int          prev;
        logic [31:0] rnd;
        sdram_word_t exp_din;

        stim_table[0] = '{1'b0, 25'h0000000, 16'h1234, 25'h0400000, 16'h3412};
        stim_table[1] = '{1'b0, 25'h0000102, 16'hABCD, 25'h0400102, 16'hCDAB};
        stim_table[2] = '{1'b0, 25'h0003FFF, 16'h00FF, 25'h0403FFE, 16'hFF00};
        stim_table[3] = '{1'b0, 25'h1C00005, 16'h5AA5, 25'h0400004, 16'hA55A};
        stim_table[4] = '{1'b1, 25'h0000010, 16'hBEEF, 25'h0000010, 16'hBEEF};
        stim_table[5] = '{1'b1, 25'h0001FFE, 16'hC0DE, 25'h0001FFE, 16'hC0DE};
        stim_table[6] = '{1'b1, 25'h0000101, 16'h7788, 25'h0000101, 16'h7788};

        cditop_reset = 1'b1;
        core_hold = 1'b1;
        osd_open = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_index = '0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        core_addr = '0;
        core_din = '0;
        core_rd = 1'b0;
        core_wr = 1'b0;
        core_word = 1'b0;
        core_refresh = 1'b0;
        core_burst = 1'b0;
        sdram_busy = 1'b0;
        nvram_media_change = 1'b0;
        img_size = '0;
        nvram_hps_ack = 1'b0;
        sd_buff_addr = '0;
        sd_buff_wr = 1'b0;
        sd_buff_dout = '0;
        nvram_cpu_changed = 1'b0;
        nvram_backup_data = '0;
        for (int i = 0; i < 16; i++) begin
            nv_mem[i] = '0;
        end
        repeat (3) tick();
        cditop_reset = 1'b0;
        tick();

        // ROM download, then a write on top of a latched one
        start_test();
        ioctl_download = 1'b1;
        tick();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!stim_table[i].slave) begin
                prev = wr_count;
                load_word(i);
                n = 0;
                while (wr_count == prev && n < 30) begin
                    tick();
                    n++;
                end
                if (wr_count == prev) begin
                    timeout_error("an SDRAM write of a ROM word");
                end
                check_addr("sdram_addr", last_wr_addr, stim_table[i].exp_addr);
                check_word("sdram_din", last_wr_din, stim_table[i].exp_word);
                wait_refresh();
                if (wr_count != prev + 1) begin
                    $display("ROM entry %0d gave %0d SDRAM writes instead of one", i,
                             wr_count - prev);
                    errors++;
                end
            end
        end
        load_word(0);
        load_word(1);
        check_bit("download_overflow", download_overflow, 1'b1);
        wait_refresh();
        ioctl_download = 1'b0;
        tick();
        ioctl_download = 1'b1;
        tick();
        check_bit("download_overflow", download_overflow, 1'b0);
        end_test("rom_download");

        // Refresh while held, then pass-through
        start_test();
        for (int k = 0; k < 4; k++) begin
            prev = acc_count;
            n = 0;
            while (acc_count == prev && n < 20) begin
                tick();
                n++;
            end
            if (acc_count == prev) begin
                timeout_error("a refresh command");
            end
            check_bit("sdram_rd", last_rd, 1'b1);
            check_bit("sdram_wr", last_wr, 1'b0);
            check_bit("sdram_refresh", last_refresh, 1'b1);
            check_bit("sdram_word", last_word, 1'b1);
            check_bit("sdram_burst", last_burst, 1'b0);
        end
        core_hold = 1'b0;
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            core_addr = rnd[24:0];
            rnd = $random(seed);
            core_din = rnd[15:0];
            core_rd = rnd[16];
            core_wr = rnd[17];
            core_word = rnd[18];
            core_refresh = rnd[19];
            core_burst = rnd[20];
            @(negedge clk_sys);
            check_addr("sdram_addr", sdram_addr, core_addr);
            check_word("sdram_din", sdram_din, core_din);
            check_bit("sdram_rd", sdram_rd, core_rd);
            check_bit("sdram_wr", sdram_wr, core_wr);
            check_bit("sdram_word", sdram_word, core_word);
            check_bit("sdram_refresh", sdram_refresh, core_refresh);
            check_bit("sdram_burst", sdram_burst, core_burst);
            tick();
        end
        core_rd = 1'b0;
        core_wr = 1'b0;
        end_test("refresh_passthrough");

        // WORM split
        start_test();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stim_table[i].slave) begin
                worm_count = 0;
                load_word(i);
                n = 0;
                while (worm_count < 2 && n < 10) begin
                    tick();
                    n++;
                end
                if (worm_count < 2) begin
                    timeout_error("two WORM byte writes");
                end
                check_nv_addr("worm_adr", worm_log_adr[0], stim_table[i].exp_addr[12:0]);
                check_byte("worm_data", worm_log_data[0], stim_table[i].exp_word[7:0]);
                check_nv_addr("worm_adr", worm_log_adr[1],
                              stim_table[i].exp_addr[12:0] | 13'h0001);
                check_byte("worm_data", worm_log_data[1], stim_table[i].exp_word[15:8]);
                tick();
            end
        end
        end_test("worm_split");

        // Restore from a mounted image
        start_test();
        nvram_media_change = 1'b1;
        img_size = 64'd8192;
        tick();
        nvram_media_change = 1'b0;
        n = 0;
        while (!nvram_hps_rd && n < 20) begin
            tick();
            n++;
        end
        if (!nvram_hps_rd) begin
            timeout_error("the restore request");
        end
        nvram_hps_ack = 1'b1;
        tick();
        for (int i = 0; i < 8; i++) begin
            rst_words[i] = sdram_word_t'($random(seed));
            sd_buff_wr = 1'b1;
            sd_buff_dout = rst_words[i];
            tick();
            sd_buff_wr = 1'b0;
            check_bit("nvram_allow_cpu_access", nvram_allow_cpu_access, 1'b0);
            tick();
            tick();
        end
        tick();
        nvram_hps_ack = 1'b0;
        wait_cpu_access();
        for (int i = 0; i < 8; i++) begin
            check_byte("nvram_restore_data", nv_mem[2 * i], rst_words[i][7:0]);
            check_byte("nvram_restore_data", nv_mem[2 * i + 1], rst_words[i][15:8]);
        end
        end_test("restore");

        // Change detection, cooldown restart and backup
        start_test();
        core_rd = 1'b1;
        nvram_cpu_changed = 1'b1;
        tick();
        nvram_cpu_changed = 1'b0;
        repeat (1000) tick();
        check_bit("led_user", led_user, 1'b0);
        nvram_cpu_changed = 1'b1;
        tick();
        nvram_cpu_changed = 1'b0;
        n = 0;
        while (!led_user && n < 6000) begin
            tick();
            n++;
        end
        if (!led_user) begin
            timeout_error("the backup pending flag");
        end else if (n != 4095) begin
            $display("Backup flagged after %0d core reads instead of 4095", n);
            errors++;
        end
        core_rd = 1'b0;
        osd_open = 1'b1;
        n = 0;
        while (!nvram_hps_wr && n < 20) begin
            tick();
            n++;
        end
        if (!nvram_hps_wr) begin
            timeout_error("the backup request");
        end
        check_bit("led_user", led_user, 1'b0);
        osd_open = 1'b0;
        nvram_hps_ack = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (i != 0) begin
                sd_buff_addr = sd_buff_addr + 8'd1;
            end
            repeat (5) tick();
            check_bit("nvram_allow_cpu_access", nvram_allow_cpu_access, 1'b0);
            exp_din = {nv_mem[2 * i + 1], nv_mem[2 * i]};
            check_word("nvram_hps_din", nvram_hps_din, exp_din);
        end
        nvram_hps_ack = 1'b0;
        wait_cpu_access();
        end_test("backup");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog/cdi_glue_defines.svh
`ifndef CDI_GLUE_DEFINES_SVH
`define CDI_GLUE_DEFINES_SVH

// ==================================================
// Loader and SDRAM layout
// ==================================================

// Upper three address bits of the boot ROM region in SDRAM
`define CDI_ROM_REGION 3'b001

// Loader index bit which marks a slave WORM file
// boot0.rom comes as index 16'h0000, boot1.rom as 16'h0040
`define CDI_LOADER_SLAVE_BIT 6

// ==================================================
// NvRAM backup timing
// ==================================================

// Width of the cooldown counter, counted in core memory reads
`define CDI_COOLDOWN_BITS 12

// Four seconds at 30 MHz
`define CDI_BOOT_IGNORE_DEFAULT 120000000

`endif

//--- verilog/cdi_glue_pkg.sv
package cdi_glue_pkg;

    // SDRAM side
    typedef logic [24:0] sdram_addr_t;
    typedef logic [15:0] sdram_word_t;

    // Loader side
    typedef logic [24:0] loader_addr_t;
    typedef logic [15:0] loader_index_t;

    typedef logic [7:0] byte_t;

    // 8 kB NvRAM, the slave WORM has the same size
    typedef logic [12:0] nvram_addr_t;
    typedef nvram_addr_t worm_addr_t;

    // Who drives SDRAM while the core is held
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        REFRESH,
        IDLE
    } sdram_owner_e;

    typedef enum logic [3:0] {
        NVRAM_IDLE,
        NVRAM_WAIT_FOR_ACK,
        NVRAM_BACKUP0,
        NVRAM_BACKUP1,
        NVRAM_BACKUP2,
        NVRAM_BACKUP3,
        NVRAM_RESTORE0,
        NVRAM_RESTORE1,
        NVRAM_RESTORE2
    } nvram_state_e;

endpackage

//--- verilog/cdi_host_glue.sv
`timescale 1ns/10ps
`include "cdi_glue_defines.svh"

module cdi_host_glue
    import cdi_glue_pkg::*;
#(
    parameter int BOOT_IGNORE_CYCLES = `CDI_BOOT_IGNORE_DEFAULT
) (
    input  logic          clk_sys,
    input  logic          cditop_reset,
    input  logic          core_hold,
    input  logic          osd_open,
    // Loader
    input  logic          ioctl_download,
    input  logic          ioctl_wr,
    input  loader_index_t ioctl_index,
    input  loader_addr_t  ioctl_addr,
    input  sdram_word_t   ioctl_dout,
    output logic          download_overflow,
    // Core SDRAM requests
    input  sdram_addr_t   core_addr,
    input  sdram_word_t   core_din,
    input  logic          core_rd,
    input  logic          core_wr,
    input  logic          core_word,
    input  logic          core_refresh,
    input  logic          core_burst,
    // SDRAM controller
    output sdram_addr_t   sdram_addr,
    output sdram_word_t   sdram_din,
    output logic          sdram_rd,
    output logic          sdram_wr,
    output logic          sdram_word,
    output logic          sdram_refresh,
    output logic          sdram_burst,
    input  logic          sdram_busy,
    // Slave WORM
    output worm_addr_t    worm_adr,
    output byte_t         worm_data,
    output logic          worm_wr,
    // SD block interface
    input  logic          nvram_media_change,
    input  logic [63:0]   img_size,
    input  logic          nvram_hps_ack,
    input  logic [7:0]    sd_buff_addr,
    input  logic          sd_buff_wr,
    input  sdram_word_t   sd_buff_dout,
    output logic          nvram_hps_rd,
    output logic          nvram_hps_wr,
    output sdram_word_t   nvram_hps_din,
    // Core NvRAM
    input  logic          nvram_cpu_changed,
    input  byte_t         nvram_backup_data,
    output nvram_addr_t   nvram_backup_restore_adr,
    output byte_t         nvram_restore_data,
    output logic          nvram_restore_write,
    output logic          nvram_allow_cpu_access,
    // Lit while a backup is pending
    output logic          led_user
);

    logic image_mounted;
    logic backup_start;

    sdram_prepare_arbiter arbiter_i (
        .clk_sys, .cditop_reset, .core_hold,
        .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
        .sdram_busy,
        .core_addr, .core_din, .core_rd, .core_wr, .core_word, .core_refresh, .core_burst,
        .sdram_addr, .sdram_din, .sdram_rd, .sdram_wr, .sdram_word, .sdram_refresh,
        .sdram_burst, .download_overflow
    );

    worm_byte_splitter splitter_i (
        .clk_sys, .cditop_reset,
        .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
        .worm_adr, .worm_data, .worm_wr
    );

    nvram_change_monitor #(
        .BOOT_IGNORE_CYCLES(BOOT_IGNORE_CYCLES)
    ) monitor_i (
        .clk_sys, .cditop_reset, .nvram_cpu_changed, .image_mounted, .core_rd,
        .backup_start,
        .backup_pending(led_user)
    );

    nvram_transfer_sequencer sequencer_i (
        .clk_sys, .cditop_reset, .osd_open, .nvram_media_change, .img_size,
        .nvram_hps_ack, .sd_buff_addr, .sd_buff_wr, .sd_buff_dout, .nvram_backup_data,
        .backup_pending(led_user),
        .nvram_hps_rd, .nvram_hps_wr, .nvram_hps_din,
        .nvram_backup_restore_adr, .nvram_restore_data, .nvram_restore_write,
        .nvram_allow_cpu_access, .image_mounted, .backup_start
    );

endmodule

//--- verilog/nvram_change_monitor.sv
`timescale 1ns/10ps
`include "cdi_glue_defines.svh"

module nvram_change_monitor #(
    parameter int BOOT_IGNORE_CYCLES = `CDI_BOOT_IGNORE_DEFAULT
) (
    input  logic clk_sys,
    input  logic cditop_reset,
    input  logic nvram_cpu_changed,
    input  logic image_mounted,
    input  logic core_rd,
    input  logic backup_start,
    output logic backup_pending
);

    localparam int IGNORE_BITS = $clog2(BOOT_IGNORE_CYCLES + 2);

    // The OS writes NvRAM during boot, those writes are not worth a backup
    logic [IGNORE_BITS-1:0]        ignore_cnt;
    logic [`CDI_COOLDOWN_BITS-1:0] cooldown;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            ignore_cnt     <= IGNORE_BITS'(BOOT_IGNORE_CYCLES);
            cooldown       <= '0;
            backup_pending <= 1'b0;
        end else begin
            if (backup_start) begin
                backup_pending <= 1'b0;
            end

            if (ignore_cnt != 0) begin
                ignore_cnt <= ignore_cnt - 1'b1;
            end else if (nvram_cpu_changed && image_mounted) begin
                // Every CPU write restarts the wait
                cooldown <= '1;
            end else if (cooldown != 0 && core_rd) begin
                // Quiet period measured in core memory reads
                if (cooldown == 1) begin
                    backup_pending <= 1'b1;
                end
                cooldown <= cooldown - 1'b1;
            end
        end
    end

endmodule

//--- verilog/nvram_transfer_sequencer.sv
`timescale 1ns/10ps

module nvram_transfer_sequencer
    import cdi_glue_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  logic        osd_open,
    input  logic        nvram_media_change,
    input  logic [63:0] img_size,
    input  logic        nvram_hps_ack,
    input  logic [7:0]  sd_buff_addr,
    input  logic        sd_buff_wr,
    input  sdram_word_t sd_buff_dout,
    input  byte_t       nvram_backup_data,
    input  logic        backup_pending,
    output logic        nvram_hps_rd,
    output logic        nvram_hps_wr,
    output sdram_word_t nvram_hps_din,
    output nvram_addr_t nvram_backup_restore_adr,
    output byte_t       nvram_restore_data,
    output logic        nvram_restore_write,
    output logic        nvram_allow_cpu_access,
    output logic        image_mounted,
    output logic        backup_start
);

    nvram_state_e state;

    logic        img_mount;
    logic        buff_addr_q;
    sdram_word_t restore_word;

    // Mounting a non-empty image triggers a restore
    assign img_mount = nvram_media_change && (img_size != 0);

    // Backup only with the OSD open, the core is paused then
    assign backup_start = (state == NVRAM_IDLE) && !img_mount && backup_pending && osd_open;

    // Even address takes the low byte
    assign nvram_restore_data = nvram_backup_restore_adr[0] ? restore_word[15:8]
                                                            : restore_word[7:0];

    // ==================================================
    // Transfer FSM
    // ==================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state                    <= NVRAM_IDLE;
            nvram_hps_rd             <= 1'b0;
            nvram_hps_wr             <= 1'b0;
            nvram_restore_write      <= 1'b0;
            nvram_allow_cpu_access   <= 1'b1;
            nvram_backup_restore_adr <= '0;
            image_mounted            <= 1'b0;
            buff_addr_q              <= 1'b0;
        end else begin
            buff_addr_q         <= sd_buff_addr[0];
            nvram_restore_write <= 1'b0;

            if (nvram_media_change) begin
                image_mounted <= (img_size != 0);
            end

            // Request is dropped on the first ack
            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                NVRAM_IDLE: begin
                    nvram_allow_cpu_access   <= 1'b1;
                    nvram_backup_restore_adr <= '0;
                    if (img_mount) begin
                        nvram_hps_rd           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= NVRAM_WAIT_FOR_ACK;
                    end else if (backup_start) begin
                        nvram_hps_wr           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= NVRAM_WAIT_FOR_ACK;
                    end
                end
                NVRAM_WAIT_FOR_ACK: begin
                    if (nvram_hps_ack && nvram_hps_rd) begin
                        state <= NVRAM_RESTORE0;
                    end
                    if (nvram_hps_ack && nvram_hps_wr) begin
                        state <= NVRAM_BACKUP0;
                    end
                end

                // Address runs one ahead to cover the read latency
                NVRAM_BACKUP0: begin
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_BACKUP1;
                end
                NVRAM_BACKUP1: begin
                    nvram_hps_din[7:0]       <= nvram_backup_data;
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_BACKUP2;
                end
                NVRAM_BACKUP2: begin
                    nvram_hps_din[15:8] <= nvram_backup_data;
                    state               <= NVRAM_BACKUP3;
                end
                NVRAM_BACKUP3: begin
                    // Host moved on to the next word
                    if (buff_addr_q != sd_buff_addr[0]) begin
                        nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                        state                    <= NVRAM_BACKUP1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= NVRAM_IDLE;
                    end
                end

                NVRAM_RESTORE0: begin
                    if (sd_buff_wr) begin
                        restore_word        <= sd_buff_dout;
                        nvram_restore_write <= 1'b1;
                        state               <= NVRAM_RESTORE1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= NVRAM_IDLE;
                    end
                end
                NVRAM_RESTORE1: begin
                    nvram_restore_write      <= 1'b1;
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_RESTORE2;
                end
                NVRAM_RESTORE2: begin
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_RESTORE0;
                end
                default: state <= NVRAM_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/sdram_prepare_arbiter.sv
`timescale 1ns/10ps
`include "cdi_glue_defines.svh"

module sdram_prepare_arbiter
    import cdi_glue_pkg::*;
(
    input  logic          clk_sys,
    input  logic          cditop_reset,
    input  logic          core_hold,
    input  logic          ioctl_download,
    input  logic          ioctl_wr,
    input  loader_index_t ioctl_index,
    input  loader_addr_t  ioctl_addr,
    input  sdram_word_t   ioctl_dout,
    input  logic          sdram_busy,
    input  sdram_addr_t   core_addr,
    input  sdram_word_t   core_din,
    input  logic          core_rd,
    input  logic          core_wr,
    input  logic          core_word,
    input  logic          core_refresh,
    input  logic          core_burst,
    output sdram_addr_t   sdram_addr,
    output sdram_word_t   sdram_din,
    output logic          sdram_rd,
    output logic          sdram_wr,
    output logic          sdram_word,
    output logic          sdram_refresh,
    output logic          sdram_burst,
    output logic          download_overflow
);

    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;

    logic        rom_wr;
    logic        wr_latch;
    logic        write_done;
    logic        busy_q;
    logic        download_q;
    sdram_addr_t latch_addr;
    sdram_word_t latch_data;

    logic prep_rd;
    logic prep_wr;
    logic prep_refresh;

    assign rom_wr = ioctl_wr && !ioctl_index[`CDI_LOADER_SLAVE_BIT];

    // Falling busy ends the download write
    assign write_done = (owner_q == ROM_DOWNLOAD) && busy_q && !sdram_busy;

    // Pending download has priority over refresh
    // A write that has just finished is not offered again
    always_comb begin
        owner_next = IDLE;
        if (core_hold) begin
            owner_next = (wr_latch && !write_done) ? ROM_DOWNLOAD : REFRESH;
        end
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_comb begin
        prep_rd      = 1'b0;
        prep_wr      = 1'b0;
        prep_refresh = 1'b0;
        case (owner)
            ROM_DOWNLOAD: prep_wr = 1'b1;
            REFRESH: begin
                prep_rd      = 1'b1;
                prep_refresh = 1'b1;
            end
            default: ;
        endcase
        // Controller takes nothing new while busy
        if (sdram_busy) begin
            prep_rd = 1'b0;
            prep_wr = 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            wr_latch          <= 1'b0;
            download_overflow <= 1'b0;
            owner_q           <= IDLE;
            busy_q            <= 1'b0;
            download_q        <= 1'b0;
        end else begin
            busy_q     <= sdram_busy;
            download_q <= ioctl_download;
            owner_q    <= owner;

            if (ioctl_download && !download_q) begin
                download_overflow <= 1'b0;
            end else if (wr_latch && ioctl_wr) begin
                download_overflow <= 1'b1;
            end

            if (write_done) begin
                wr_latch <= 1'b0;
            end
            if (rom_wr) begin
                wr_latch <= 1'b1;
            end
        end
    end

    // Word aligned into the ROM region, bytes swapped to big endian for the 68k
    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            latch_addr <= {`CDI_ROM_REGION, ioctl_addr[21:1], 1'b0};
            latch_data <= {ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

    always_comb begin
        if (core_hold) begin
            sdram_addr    = latch_addr;
            sdram_din     = latch_data;
            sdram_rd      = prep_rd;
            sdram_wr      = prep_wr;
            sdram_word    = 1'b1;
            sdram_refresh = prep_refresh;
            sdram_burst   = 1'b0;
        end else begin
            sdram_addr    = core_addr;
            sdram_din     = core_din;
            sdram_rd      = core_rd;
            sdram_wr      = core_wr;
            sdram_word    = core_word;
            sdram_refresh = core_refresh;
            sdram_burst   = core_burst;
        end
    end

endmodule

//--- verilog/worm_byte_splitter.sv
`timescale 1ns/10ps
`include "cdi_glue_defines.svh"

module worm_byte_splitter
    import cdi_glue_pkg::*;
(
    input  logic          clk_sys,
    input  logic          cditop_reset,
    input  logic          ioctl_wr,
    input  loader_index_t ioctl_index,
    input  loader_addr_t  ioctl_addr,
    input  sdram_word_t   ioctl_dout,
    output worm_addr_t    worm_adr,
    output byte_t         worm_data,
    output logic          worm_wr
);

    logic  slave_wr;
    logic  slave_wr_q;
    byte_t high_byte;

    assign slave_wr = ioctl_wr && ioctl_index[`CDI_LOADER_SLAVE_BIT];

    // Two write cycles per loader word
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            slave_wr_q <= 1'b0;
            worm_wr    <= 1'b0;
        end else begin
            slave_wr_q <= slave_wr;
            worm_wr    <= slave_wr || slave_wr_q;
        end
    end

    // Low byte goes first, high byte waits one cycle
    always_ff @(posedge clk_sys) begin
        if (slave_wr) begin
            worm_adr  <= ioctl_addr[12:0];
            worm_data <= ioctl_dout[7:0];
            high_byte <= ioctl_dout[15:8];
        end else if (slave_wr_q) begin
            worm_adr[0] <= 1'b1;
            worm_data   <= high_byte;
        end
    end

endmodule
